// File: design/ex_pkg.sv
package ex_pkg;

    localparam int WORD_W   = 32;
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int SHAMT_W  = 5;
    localparam int IMM_W    = 16;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT_W-1:0]  funct_t;
    typedef logic [SHAMT_W-1:0]  shamt_t;
    typedef logic [IMM_W-1:0]    imm_t;

    localparam opcode_t RTYPE_OPCODE = 6'b000000;
    localparam opcode_t ADDI_OPCODE  = 6'b001000;
    localparam opcode_t SLTI_OPCODE  = 6'b001010;
    localparam opcode_t ANDI_OPCODE  = 6'b001100;
    localparam opcode_t ORI_OPCODE   = 6'b001101;
    localparam opcode_t XORI_OPCODE  = 6'b001110;
    localparam opcode_t LUI_OPCODE   = 6'b001111;
    localparam opcode_t BEQ_OPCODE   = 6'b000100;
    localparam opcode_t BNE_OPCODE   = 6'b000101;
    localparam opcode_t LB_OPCODE    = 6'b100000;
    localparam opcode_t LH_OPCODE    = 6'b100001;
    localparam opcode_t LW_OPCODE    = 6'b100011;
    localparam opcode_t LBU_OPCODE   = 6'b100100;
    localparam opcode_t LHU_OPCODE   = 6'b100101;
    localparam opcode_t LWU_OPCODE   = 6'b100111;
    localparam opcode_t SW_OPCODE    = 6'b101011;

    localparam funct_t SLL_FCODE  = 6'b000000;
    localparam funct_t SRL_FCODE  = 6'b000010;
    localparam funct_t SRA_FCODE  = 6'b000011;
    localparam funct_t SLLV_FCODE = 6'b000100;
    localparam funct_t SRLV_FCODE = 6'b000110;
    localparam funct_t SRAV_FCODE = 6'b000111;
    localparam funct_t ADD_FCODE  = 6'b100000;
    localparam funct_t ADDU_FCODE = 6'b100001;
    localparam funct_t SUB_FCODE  = 6'b100010;
    localparam funct_t SUBU_FCODE = 6'b100011;
    localparam funct_t AND_FCODE  = 6'b100100;
    localparam funct_t OR_FCODE   = 6'b100101;
    localparam funct_t XOR_FCODE  = 6'b100110;
    localparam funct_t NOR_FCODE  = 6'b100111;
    localparam funct_t SLT_FCODE  = 6'b101010;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0, // Default operation
        ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_BNE
    } alu_op_e;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
        shamt_t  shamt;
        word_t   rs_data;
        word_t   rt_data;
        imm_t    imm;
    } ex_request_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    shamt_ctrl;   // A from shamt field
        logic    use_imm;      // B from immediate
        logic    imm_zero_ext; // Zero instead of sign extension
    } ex_ctrl_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } ex_operands_t;

    typedef struct packed {
        word_t data;
        logic  zero;
    } ex_result_t;

endpackage

// File: design/ex_control.sv
`timescale 1ns/1ps

module ex_control (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_req_valid,
    output logic             o_req_ready,
    input  ex_pkg::opcode_t  i_opcode,
    input  ex_pkg::funct_t   i_funct,
    input  logic             i_res_ready,
    output logic             o_res_valid,
    output ex_pkg::ex_ctrl_t o_ctrl,
    output logic             o_load
);
    import ex_pkg::*;

    logic res_valid_q;

    // Stage drains or is empty
    assign o_req_ready = !res_valid_q || i_res_ready;
    assign o_load      = i_req_valid && o_req_ready;
    assign o_res_valid = res_valid_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            res_valid_q <= 1'b0;
        end else if (o_load) begin
            res_valid_q <= 1'b1;
        end else if (i_res_ready) begin
            res_valid_q <= 1'b0; // Consumed, nothing new
        end
    end

    always_comb begin
        o_ctrl.alu_op       = ALU_ADD; // Unknown codes fall back to rs + rt
        o_ctrl.shamt_ctrl   = 1'b0;
        o_ctrl.use_imm      = 1'b0;
        o_ctrl.imm_zero_ext = 1'b0;

        case (i_opcode)
            RTYPE_OPCODE: begin
                case (i_funct)
                    ADD_FCODE, ADDU_FCODE: o_ctrl.alu_op = ALU_ADD;
                    SUB_FCODE, SUBU_FCODE: o_ctrl.alu_op = ALU_SUB;
                    AND_FCODE:             o_ctrl.alu_op = ALU_AND;
                    OR_FCODE:              o_ctrl.alu_op = ALU_OR;
                    XOR_FCODE:             o_ctrl.alu_op = ALU_XOR;
                    NOR_FCODE:             o_ctrl.alu_op = ALU_NOR;
                    SLT_FCODE:             o_ctrl.alu_op = ALU_SLT;
                    SLL_FCODE: begin
                        o_ctrl.alu_op     = ALU_SLL;
                        o_ctrl.shamt_ctrl = 1'b1;
                    end
                    SRL_FCODE: begin
                        o_ctrl.alu_op     = ALU_SRL;
                        o_ctrl.shamt_ctrl = 1'b1;
                    end
                    SRA_FCODE: begin
                        o_ctrl.alu_op     = ALU_SRA;
                        o_ctrl.shamt_ctrl = 1'b1;
                    end
                    SLLV_FCODE:            o_ctrl.alu_op = ALU_SLL; // Amount from rs
                    SRLV_FCODE:            o_ctrl.alu_op = ALU_SRL;
                    SRAV_FCODE:            o_ctrl.alu_op = ALU_SRA;
                    default:               o_ctrl.alu_op = ALU_ADD;
                endcase
            end
            ADDI_OPCODE: begin
                o_ctrl.alu_op  = ALU_ADD;
                o_ctrl.use_imm = 1'b1;
            end
            SLTI_OPCODE: begin
                o_ctrl.alu_op  = ALU_SLT;
                o_ctrl.use_imm = 1'b1;
            end
            ANDI_OPCODE: begin
                o_ctrl.alu_op       = ALU_AND;
                o_ctrl.use_imm      = 1'b1;
                o_ctrl.imm_zero_ext = 1'b1;
            end
            ORI_OPCODE: begin
                o_ctrl.alu_op       = ALU_OR;
                o_ctrl.use_imm      = 1'b1;
                o_ctrl.imm_zero_ext = 1'b1;
            end
            XORI_OPCODE: begin
                o_ctrl.alu_op       = ALU_XOR;
                o_ctrl.use_imm      = 1'b1;
                o_ctrl.imm_zero_ext = 1'b1;
            end
            LUI_OPCODE: begin
                o_ctrl.alu_op  = ALU_LUI;
                o_ctrl.use_imm = 1'b1;
            end
            BEQ_OPCODE: o_ctrl.alu_op = ALU_SUB; // Zero when rs == rt
            BNE_OPCODE: o_ctrl.alu_op = ALU_BNE;
            LB_OPCODE, LBU_OPCODE, LH_OPCODE, LHU_OPCODE,
            LW_OPCODE, LWU_OPCODE, SW_OPCODE: begin
                o_ctrl.alu_op  = ALU_ADD; // Base plus offset
                o_ctrl.use_imm = 1'b1;
            end
            default: begin
                o_ctrl.alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

// File: design/ex_operand_select.sv
`timescale 1ns/1ps

module ex_operand_select (
    input  ex_pkg::ex_request_t  i_req,
    input  ex_pkg::ex_ctrl_t     i_ctrl,
    output ex_pkg::ex_operands_t o_operands
);
    import ex_pkg::*;

    word_t imm_ext;
    word_t shamt_ext;

    // ANDI, ORI and XORI treat the immediate as unsigned
    always_comb begin
        if (i_ctrl.imm_zero_ext) begin
            imm_ext = {{(WORD_W-IMM_W){1'b0}}, i_req.imm};
        end else begin
            imm_ext = {{(WORD_W-IMM_W){i_req.imm[IMM_W-1]}}, i_req.imm};
        end
    end

    assign shamt_ext = {{(WORD_W-SHAMT_W){1'b0}}, i_req.shamt};

    always_comb begin
        if (i_ctrl.shamt_ctrl) begin
            o_operands.a = shamt_ext; // Fixed shifts
        end else begin
            o_operands.a = i_req.rs_data;
        end

        if (i_ctrl.use_imm) begin
            o_operands.b = imm_ext;
        end else begin
            o_operands.b = i_req.rt_data;
        end
    end

endmodule

// File: design/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_load,
    input  ex_pkg::alu_op_e      i_alu_op,
    input  ex_pkg::ex_operands_t i_operands,
    output ex_pkg::ex_result_t   o_result
);
    import ex_pkg::*;

    word_t  a;
    word_t  b;
    shamt_t sh;
    word_t  alu_data;
    ex_result_t result_q;

    assign a  = i_operands.a;
    assign b  = i_operands.b;
    assign sh = a[SHAMT_W-1:0]; // Only the low five bits shift

    always_comb begin
        case (i_alu_op)
            ALU_ADD: alu_data = a + b;
            ALU_SUB: alu_data = a - b;
            ALU_AND: alu_data = a & b;
            ALU_OR:  alu_data = a | b;
            ALU_XOR: alu_data = a ^ b;
            ALU_NOR: alu_data = ~(a | b);
            ALU_SLT: begin
                alu_data = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            end
            ALU_SLL: alu_data = b << sh;
            ALU_SRL: alu_data = b >> sh;
            ALU_SRA: alu_data = word_t'($signed(b) >>> sh);
            ALU_LUI: alu_data = {b[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
            ALU_BNE: begin
                // Zero result means taken, same as BEQ through SUB
                alu_data = (a != b) ? word_t'(0) : word_t'(1);
            end
            default: alu_data = a + b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            result_q <= '0;
        end else if (i_load) begin
            result_q.data <= alu_data;
            result_q.zero <= (alu_data == '0);
        end
    end

    assign o_result = result_q;

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_req_valid,
    output logic                o_req_ready,
    input  ex_pkg::ex_request_t i_req,
    output logic                o_res_valid,
    input  logic                i_res_ready,
    output ex_pkg::ex_result_t  o_res
);
    import ex_pkg::*;

    ex_ctrl_t     ctrl;
    ex_operands_t operands;
    logic         load;

    ex_control ex_control_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_opcode    (i_req.opcode),
        .i_funct     (i_req.funct),
        .i_res_ready (i_res_ready),
        .o_res_valid (o_res_valid),
        .o_ctrl      (ctrl),
        .o_load      (load)
    );

    ex_operand_select ex_operand_select_inst (
        .i_req      (i_req),
        .i_ctrl     (ctrl),
        .o_operands (operands)
    );

    ex_alu ex_alu_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_load     (load),
        .i_alu_op   (ctrl.alu_op),
        .i_operands (operands),
        .o_result   (o_res)
    );

endmodule

// File: tests/ex_stage_assert.sv
`timescale 1ns/1ps

module ex_stage_assert (
    input logic               i_clk,
    input logic               i_reset,
    input logic               o_req_ready,
    input logic               o_res_valid,
    input logic               i_res_ready,
    input ex_pkg::ex_result_t o_res
);

    int unsigned fail_count = 0;

    // Covers the reset cycles and the first cycle after
    reset_clears_valid: assert property (@(posedge i_clk) i_reset |=> !o_res_valid)
        else begin
            $error("o_res_valid high during or right after reset");
            fail_count++;
        end

    reset_sets_ready: assert property (@(posedge i_clk) i_reset |=> o_req_ready)
        else begin
            $error("o_req_ready low right after reset");
            fail_count++;
        end

    stalled_result_holds: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_res_valid && !i_res_ready) |=> (o_res_valid && $stable(o_res)))
        else begin
            $error("o_res changed or was dropped while stalled");
            fail_count++;
        end

    ready_passes_through: assert property (@(posedge i_clk) disable iff (i_reset)
        o_req_ready == (!o_res_valid || i_res_ready))
        else begin
            $error("o_req_ready does not follow the output side");
            fail_count++;
        end

endmodule

// File: tests/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam int          NUM_REQ    = 2000;
    localparam int unsigned SEED       = 32'h491d6de4;
    localparam int          TIMEOUT_NS = (NUM_REQ * 8 + 200) * CLK_PERIOD; // Reset and drain margin

    logic        i_clk;
    logic        i_reset;
    logic        i_req_valid;
    logic        o_req_ready;
    ex_request_t i_req;
    logic        o_res_valid;
    logic        i_res_ready;
    ex_result_t  o_res;

    ex_result_t expected_q[$];
    int         accepted = 0;
    int         consumed = 0;

    opcode_t itype_ops [15] = '{ADDI_OPCODE, SLTI_OPCODE, ANDI_OPCODE, ORI_OPCODE, XORI_OPCODE,
                                LUI_OPCODE, BEQ_OPCODE, BNE_OPCODE, LB_OPCODE, LH_OPCODE,
                                LW_OPCODE, LBU_OPCODE, LHU_OPCODE, LWU_OPCODE, SW_OPCODE};
    funct_t rtype_functs [15] = '{ADD_FCODE, ADDU_FCODE, SUB_FCODE, SUBU_FCODE, AND_FCODE,
                                  OR_FCODE, XOR_FCODE, NOR_FCODE, SLT_FCODE, SLL_FCODE,
                                  SRL_FCODE, SRA_FCODE, SLLV_FCODE, SRLV_FCODE, SRAV_FCODE};

    ex_stage ex_stage_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req       (i_req),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready),
        .o_res       (o_res)
    );

    bind ex_stage ex_stage_assert ex_stage_assert_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .o_req_ready (o_req_ready),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready),
        .o_res       (o_res)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %0t: %s got %08h expected %08h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %0t: %s got %0b expected %0b",
                                     $time, what, got, exp));
        end
    endtask

    function automatic logic is_known_opcode(input opcode_t op);
        logic known;
        known = (op == RTYPE_OPCODE);
        foreach (itype_ops[k]) known |= (op == itype_ops[k]);
        return known;
    endfunction

    function automatic logic is_known_funct(input funct_t fn);
        logic known;
        known = 1'b0;
        foreach (rtype_functs[k]) known |= (fn == rtype_functs[k]);
        return known;
    endfunction

    // Expected result per instruction
    function automatic ex_result_t model_result(input ex_request_t req);
        word_t      rs;
        word_t      rt;
        word_t      simm;
        word_t      zimm;
        word_t      d;
        ex_result_t res;
        rs   = req.rs_data;
        rt   = req.rt_data;
        simm = {{16{req.imm[15]}}, req.imm};
        zimm = {16'h0000, req.imm};
        case (req.opcode)
            RTYPE_OPCODE: begin
                case (req.funct)
                    ADD_FCODE, ADDU_FCODE: d = rs + rt;
                    SUB_FCODE, SUBU_FCODE: d = rs - rt;
                    AND_FCODE:  d = rs & rt;
                    OR_FCODE:   d = rs | rt;
                    XOR_FCODE:  d = rs ^ rt;
                    NOR_FCODE:  d = ~(rs | rt);
                    SLT_FCODE:  d = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
                    SLL_FCODE:  d = rt << req.shamt;
                    SRL_FCODE:  d = rt >> req.shamt;
                    SRA_FCODE:  d = $signed(rt) >>> req.shamt;
                    SLLV_FCODE: d = rt << rs[4:0];
                    SRLV_FCODE: d = rt >> rs[4:0];
                    SRAV_FCODE: d = $signed(rt) >>> rs[4:0];
                    default:    d = rs + rt;
                endcase
            end
            ADDI_OPCODE: d = rs + simm;
            SLTI_OPCODE: d = ($signed(rs) < $signed(simm)) ? 32'd1 : 32'd0;
            ANDI_OPCODE: d = rs & zimm;
            ORI_OPCODE:  d = rs | zimm;
            XORI_OPCODE: d = rs ^ zimm;
            LUI_OPCODE:  d = {req.imm, 16'h0000};
            BEQ_OPCODE:  d = rs - rt;
            BNE_OPCODE:  d = (rs != rt) ? 32'd0 : 32'd1;
            LB_OPCODE, LH_OPCODE, LW_OPCODE, LBU_OPCODE,
            LHU_OPCODE, LWU_OPCODE, SW_OPCODE: d = rs + simm;
            default:     d = rs + rt;
        endcase
        res.data = d;
        res.zero = (d == 32'd0);
        // Zero flag set means branch taken
        if (req.opcode == BEQ_OPCODE) res.zero = (rs == rt);
        if (req.opcode == BNE_OPCODE) res.zero = (rs != rt);
        return res;
    endfunction

    task automatic build_request(output ex_request_t req);
        int pick;
        pick        = $urandom_range(0, 99);
        req.opcode  = RTYPE_OPCODE;
        req.funct   = rtype_functs[$urandom_range(0, 14)];
        req.shamt   = shamt_t'($urandom);
        req.rs_data = $urandom;
        req.rt_data = ($urandom_range(0, 3) == 0) ? req.rs_data : word_t'($urandom);
        req.imm     = imm_t'($urandom);
        if (pick < 3) begin
            do req.opcode = opcode_t'($urandom); while (is_known_opcode(req.opcode));
        end else if (pick < 5) begin
            do req.funct = funct_t'($urandom); while (is_known_funct(req.funct));
        end else if (pick >= 50) begin
            req.opcode = itype_ops[$urandom_range(0, 14)];
        end
    endtask

    task automatic drive_requests();
        ex_request_t req;
        int          gap;
        for (int n = 0; n < NUM_REQ; n++) begin
            gap = ($urandom_range(0, 2) == 0) ? $urandom_range(1, 3) : 0;
            if (gap > 0) begin
                i_req_valid = 1'b0;
                repeat (gap) begin
                    @(posedge i_clk);
                    #1;
                end
            end
            build_request(req);
            i_req       = req;
            i_req_valid = 1'b1;
            @(negedge i_clk);
            while (!o_req_ready) @(negedge i_clk); // Held under back-pressure
            @(posedge i_clk);
            #1;
        end
        i_req_valid = 1'b0;
    endtask

    task automatic toggle_res_ready();
        forever begin
            @(posedge i_clk);
            #1;
            i_res_ready = ($urandom_range(0, 99) < 65);
        end
    endtask

    task automatic check_result(input ex_result_t got);
        ex_result_t exp;
        if (expected_q.size() == 0) begin
            report_failure("A result came out with no request pending");
        end else begin
            exp = expected_q.pop_front();
            compare_word(got.data, exp.data, $sformatf("result %0d data", consumed));
            compare_flag(got.zero, exp.zero, $sformatf("result %0d zero flag", consumed));
            consumed++;
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Handshakes seen mid-cycle
    always @(negedge i_clk) begin
        if (ex_stage_inst.ex_stage_assert_inst.fail_count != 0) begin
            report_failure("An assertion on the ex_stage handshake failed");
        end else if (!i_reset) begin
            if (o_res_valid && i_res_ready) check_result(o_res);
            if (i_req_valid && o_req_ready) begin
                expected_q.push_back(model_result(i_req));
                accepted++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        report_failure($sformatf("Timeout with %0d of %0d results received",
                                 consumed, NUM_REQ));
    end

    initial begin
        void'($urandom(SEED));
        i_reset     = 1'b1;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_res_ready = 1'b0;
        repeat (10) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        fork
            drive_requests();
            toggle_res_ready();
        join_none
        wait (consumed == NUM_REQ);
        repeat (10) @(posedge i_clk); // Catch duplicated results
        if (accepted == NUM_REQ && consumed == NUM_REQ && expected_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure($sformatf("Got %0d results for %0d accepted requests",
                                     consumed, accepted));
        end
    end

endmodule

// File: src.f
design/ex_pkg.sv
design/ex_control.sv
design/ex_operand_select.sv
design/ex_alu.sv
design/ex_stage.sv
tests/ex_stage_assert.sv
tests/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - design/ex_pkg.sv
      - design/ex_control.sv
      - design/ex_operand_select.sv
      - design/ex_alu.sv
      - design/ex_stage.sv
  - target: test
    files:
      - tests/ex_stage_assert.sv
      - tests/tb_ex_stage.sv
